/* include/memSysDefs.svh */
`ifndef MEM_SYS_DEFS_SVH
`define MEM_SYS_DEFS_SVH

// Lines in each direct-mapped cache
`define MS_LINES 16

// Words per cache block, also the length of one bus burst
`define MS_BLOCK_WORDS 4

// Cycles from the request edge to the first ready pulse
`define MS_MEM_LATENCY 2

// Depth of the simulation memory in words
`define MS_MEM_WORDS 1024

// Initial memory word at word address a is a ^ this pattern
`define MS_INIT_XOR 32'h5a3c_96e1

`endif

/* logic/burstTimer.sv */
`timescale 1ns/1ps
`include "memSysDefs.svh"

module burstTimer (
  input  logic       clk,
  input  logic       rstN,
  input  logic       start,
  output logic       ready,
  output logic [1:0] count,
  output logic       done
);

  // Edges since start was seen, covers the wait and the whole burst
  logic [$clog2(`MS_MEM_LATENCY + `MS_BLOCK_WORDS + 1)-1:0] cyc;
  logic busy;

  // Words flow once the latency has run out
  assign ready = busy && (cyc >= `MS_MEM_LATENCY);
  assign count = 2'(cyc - `MS_MEM_LATENCY);
  assign done  = ready && (count == 2'(`MS_BLOCK_WORDS - 1));

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      busy <= 1'b0;
      cyc  <= '0;
    end else if (!busy) begin
      // Idle, arm on a request level
      busy <= start;
      cyc  <= '0;
    end else if (done) begin
      busy <= 1'b0;
    end else begin
      cyc <= cyc + 1'b1;
    end
  end

endmodule

/* logic/busArbiter.sv */
`timescale 1ns/1ps

module busArbiter (
  input  logic               clk,
  input  logic               rstN,
  input  memSysPkg::busReq_t instrReq,
  input  memSysPkg::busReq_t dataReq,
  output memSysPkg::busRsp_t instrRsp,
  output memSysPkg::busRsp_t dataRsp,
  output memSysPkg::busReq_t memReq,
  input  memSysPkg::busRsp_t memRsp
);

  // Grant is held while active, owner picks the side
  logic active;
  logic ownerData;
  logic selData;

  // Data side wins when the bus is free
  assign selData = active ? ownerData : dataReq.request;
  // Owner dropping its request leaves the bus idle for one cycle
  assign memReq  = selData ? dataReq : instrReq;

  always_comb begin
    instrRsp.rdata = memRsp.rdata;
    dataRsp.rdata  = memRsp.rdata;
    instrRsp.ready = memRsp.ready && !selData;
    dataRsp.ready  = memRsp.ready && selData;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      active    <= 1'b0;
      ownerData <= 1'b0;
    end else begin
      active    <= memReq.request;
      ownerData <= selData;
    end
  end

  // Each word reaches exactly one side, and that side is still asking
  assert property (@(posedge clk) disable iff (!rstN)
    memRsp.ready |-> (instrRsp.ready ^ dataRsp.ready) && memReq.request)
    else $error("ready pulse routed to both sides or to an idle requester");

endmodule

/* logic/busMemory.sv */
`timescale 1ns/1ps
`include "memSysDefs.svh"

module busMemory (
  input  logic               clk,
  input  logic               rstN,
  input  memSysPkg::busReq_t memReq,
  output memSysPkg::busRsp_t memRsp
);

  import memSysPkg::*;

  logic [31:0] mem [`MS_MEM_WORDS];
  logic ready;
  logic [1:0] count;
  logic done;
  // Word address is blockAddr * words per block + beat number
  logic [blockBits+1:0] fullAddr;
  logic [$clog2(`MS_MEM_WORDS)-1:0] wordAddr;

  burstTimer timer (
    .clk  (clk),
    .rstN (rstN),
    .start(memReq.request),
    .ready(ready),
    .count(count),
    .done (done)
  );

  assign fullAddr = {memReq.blockAddr, count};
  // Upper address bits beyond the memory depth alias
  assign wordAddr = fullAddr[$clog2(`MS_MEM_WORDS)-1:0];

  // Known pattern at time zero so reads before any write are predictable
  initial begin
    for (int a = 0; a < `MS_MEM_WORDS; a++) begin
      mem[a] = a ^ `MS_INIT_XOR;
    end
  end

  always @(posedge clk) begin
    if (ready && memReq.write) begin
      mem[wordAddr] <= memReq.wdata;
    end
  end

  always_comb begin
    memRsp.ready = ready;
    memRsp.rdata = mem[wordAddr];
  end

  // Requester keeps address and direction fixed for the whole burst
  assert property (@(posedge clk) disable iff (!rstN)
    memReq.request && $past(memReq.request) |-> $stable(memReq.blockAddr) && $stable(memReq.write))
    else $error("bus request changed address or direction mid burst");

  // Requester lets go of the bus right after the last word
  assert property (@(posedge clk) disable iff (!rstN) done |=> !memReq.request)
    else $error("bus request still high after the last ready pulse");

endmodule

/* logic/dataCacheArray.sv */
`timescale 1ns/1ps
`include "memSysDefs.svh"

module dataCacheArray (
  input  logic                          clk,
  input  logic                          rstN,
  input  memSysPkg::dataReq_t           dataReq,
  input  logic [1:0]                    wordIdx,
  input  logic                          fillWe,
  input  logic                          storeWe,
  input  logic [31:0]                   fillData,
  output logic                          hit,
  output logic                          victimDirty,
  output logic [memSysPkg::tagBits-1:0] victimTag,
  output logic [31:0]                   rdata,
  output logic [31:0]                   evictData
);

  import memSysPkg::*;

  logic [tagBits-1:0] tags [`MS_LINES];
  logic [31:0] lines [`MS_LINES][`MS_BLOCK_WORDS];
  logic [`MS_LINES-1:0] valid;
  logic [`MS_LINES-1:0] dirty;
  logic [idxBits-1:0] idx;
  logic lastFill;

  assign idx      = dataReq.addr.fields.index;
  assign lastFill = fillWe && (wordIdx == 2'(`MS_BLOCK_WORDS - 1));

  assign hit         = valid[idx] && (tags[idx] == dataReq.addr.fields.tag);
  assign victimDirty = valid[idx] && dirty[idx];
  assign victimTag   = tags[idx];
  assign rdata       = lines[idx][dataReq.addr.fields.offset];
  // Word streamed out during write-back
  assign evictData   = lines[idx][wordIdx];

  always_ff @(posedge clk) begin
    if (fillWe) begin
      lines[idx][wordIdx] <= fillData;
      if (lastFill) begin
        tags[idx] <= dataReq.addr.fields.tag;
      end
    end else if (storeWe) begin
      // Merge only the enabled byte lanes
      for (int b = 0; b < 4; b++) begin
        if (dataReq.byteMask[b]) begin
          lines[idx][dataReq.addr.fields.offset][8*b +: 8] <= dataReq.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      valid <= '0;
      dirty <= '0;
    end else if (lastFill) begin
      // Fresh line matches memory
      valid[idx] <= 1'b1;
      dirty[idx] <= 1'b0;
    end else if (storeWe) begin
      dirty[idx] <= 1'b1;
    end
  end

endmodule

/* logic/dataCacheCtrl.sv */
`timescale 1ns/1ps
`include "memSysDefs.svh"

module dataCacheCtrl (
  input  logic                              clk,
  input  logic                              rstN,
  input  memSysPkg::dataReq_t               dataReq,
  input  logic                              hit,
  input  logic                              victimDirty,
  input  logic [memSysPkg::tagBits-1:0]     victimTag,
  input  logic [31:0]                       evictData,
  output logic [1:0]                        wordIdx,
  output logic                              fillWe,
  output logic                              storeWe,
  output logic                              dStall,
  output memSysPkg::busReq_t                busReq,
  input  memSysPkg::busRsp_t                busRsp
);

  import memSysPkg::*;

  typedef enum logic [1:0] {stLookup, stWriteBack, stRefill} dState_t;

  dState_t state;
  logic access;
  logic miss;
  logic lastPulse;
  // One idle bus cycle between write-back and refill bursts
  logic pause;
  logic [tagBits+idxBits-1:0] victimBlock;

  assign access    = dataReq.read || dataReq.write;
  assign miss      = access && !hit;
  assign lastPulse = busRsp.ready && (wordIdx == 2'(`MS_BLOCK_WORDS - 1));

  assign dStall  = (state != stLookup) || miss;
  assign storeWe = (state == stLookup) && dataReq.write && hit;
  assign fillWe  = (state == stRefill) && busRsp.ready;

  // Victim lives at the same index under its old tag
  assign victimBlock = {victimTag, dataReq.addr.fields.index};

  always_comb begin
    busReq.request   = (state != stLookup) && !pause;
    busReq.write     = (state == stWriteBack);
    busReq.blockAddr = (state == stWriteBack) ? victimBlock[blockBits-1:0]
                                              : dataReq.addr.raw[blockBits+offBits+1 -: blockBits];
    // Array word at wordIdx, valid while the matching pulse is high
    busReq.wdata     = evictData;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state   <= stLookup;
      wordIdx <= '0;
      pause   <= 1'b0;
    end else begin
      pause <= 1'b0;
      if (busRsp.ready) begin
        wordIdx <= lastPulse ? '0 : wordIdx + 1'b1;
      end
      case (state)
        stLookup: if (miss) state <= victimDirty ? stWriteBack : stRefill;
        stWriteBack: begin
          if (lastPulse) begin
            state <= stRefill;
            pause <= 1'b1;
          end
        end
        // Back to lookup, where the held access now hits
        stRefill: if (lastPulse) state <= stLookup;
        default: state <= stLookup;
      endcase
    end
  end

  assert property (@(posedge clk) disable iff (!rstN) !(storeWe && fillWe))
    else $error("store and refill wrote the data array together");

  // Installed line must satisfy the access held by the core
  assert property (@(posedge clk) disable iff (!rstN)
    (state == stRefill) && lastPulse |=> hit)
    else $error("data access missed right after its refill");

endmodule

/* logic/instrCache.sv */
`timescale 1ns/1ps
`include "memSysDefs.svh"

module instrCache (
  input  logic               clk,
  input  logic               rstN,
  input  logic [31:0]        pc,
  output logic [31:0]        instr,
  output logic               iStall,
  output memSysPkg::busReq_t busReq,
  input  memSysPkg::busRsp_t busRsp
);

  import memSysPkg::*;

  typedef enum logic {stReady, stRefill} iState_t;

  iState_t state;
  memAddr_u pcAddr;
  logic [tagBits-1:0] tags [`MS_LINES];
  logic [31:0] lines [`MS_LINES][`MS_BLOCK_WORDS];
  logic [`MS_LINES-1:0] valid;
  logic [idxBits-1:0] idx;
  logic [1:0] wordCnt;
  logic hit;
  logic lastWord;

  assign pcAddr.raw = pc;
  assign idx = pcAddr.fields.index;

  // Lookup and read are both combinational on pc
  assign hit    = valid[idx] && (tags[idx] == pcAddr.fields.tag);
  assign instr  = lines[idx][pcAddr.fields.offset];
  // Low during reset, then any miss or refill stalls the fetch
  assign iStall = rstN && (!hit || (state == stRefill));

  assign lastWord = busRsp.ready && (wordCnt == 2'(`MS_BLOCK_WORDS - 1));

  // Read-only side, so every burst is a refill of the block holding pc
  always_comb begin
    busReq.request   = (state == stRefill);
    busReq.write     = 1'b0;
    busReq.blockAddr = pcAddr.raw[blockBits+offBits+1 -: blockBits];
    busReq.wdata     = '0;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state   <= stReady;
      wordCnt <= '0;
      valid   <= '0;
    end else begin
      case (state)
        stReady: if (!hit) state <= stRefill;
        stRefill: begin
          if (busRsp.ready) begin
            wordCnt <= lastWord ? '0 : wordCnt + 1'b1;
          end
          // Line becomes usable on the edge of its last word
          if (lastWord) begin
            valid[idx] <= 1'b1;
            state      <= stReady;
          end
        end
        default: state <= stReady;
      endcase
    end
  end

  // Fill words in beat order
  always_ff @(posedge clk) begin
    if ((state == stRefill) && busRsp.ready) begin
      lines[idx][wordCnt] <= busRsp.rdata;
      if (lastWord) begin
        tags[idx] <= pcAddr.fields.tag;
      end
    end
  end

  // A refill never fetches a line that is already present
  assert property (@(posedge clk) disable iff (!rstN)
    $rose(busReq.request) |-> !(valid[idx] && (tags[idx] == pcAddr.fields.tag)))
    else $error("instruction refill started for a line already valid");

endmodule

/* logic/memSysPkg.sv */
`include "memSysDefs.svh"

package memSysPkg;

  // Field widths of a byte address
  localparam int idxBits   = $clog2(`MS_LINES);
  localparam int offBits   = $clog2(`MS_BLOCK_WORDS);
  localparam int tagBits   = 32 - idxBits - offBits - 2;
  // Block address carried on the bus
  localparam int blockBits = 26;

  // Cache view of an address
  typedef struct packed {
    logic [tagBits-1:0] tag;
    logic [idxBits-1:0] index;
    logic [offBits-1:0] offset;
    logic [1:0]         byteSel;
  } addrFields_t;

  // Same word, raw for the bus side or split for the caches
  typedef union packed {
    logic [31:0] raw;
    addrFields_t fields;
  } memAddr_u;

  // Requester to memory, held stable for a whole burst
  typedef struct packed {
    logic                 request;
    logic                 write;
    logic [blockBits-1:0] blockAddr;
    logic [31:0]          wdata;
  } busReq_t;

  // Memory to requester, one ready pulse per word
  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } busRsp_t;

  // Core data port
  typedef struct packed {
    logic        read;
    logic        write;
    memAddr_u    addr;
    logic [31:0] wdata;
    logic [3:0]  byteMask;
  } dataReq_t;

endpackage

/* logic/memSystem.sv */
`timescale 1ns/1ps

module memSystem (
  input  logic                clk,
  input  logic                rstN,
  input  logic [31:0]         pc,
  output logic [31:0]         instr,
  output logic                iStall,
  input  memSysPkg::dataReq_t dataReq,
  output logic [31:0]         rdata,
  output logic                dStall
);

  import memSysPkg::*;

  busReq_t iBusReq, dBusReq, memReq;
  busRsp_t iBusRsp, dBusRsp, memRsp;
  // Data cache controller to array
  logic hit;
  logic victimDirty;
  logic [tagBits-1:0] victimTag;
  logic [1:0] wordIdx;
  logic fillWe;
  logic storeWe;
  logic [31:0] evictData;

  instrCache iCache (
    .clk(clk), .rstN(rstN), .pc(pc), .instr(instr), .iStall(iStall),
    .busReq(iBusReq), .busRsp(iBusRsp)
  );

  dataCacheCtrl dCtrl (
    .clk(clk), .rstN(rstN), .dataReq(dataReq), .hit(hit), .victimDirty(victimDirty),
    .victimTag(victimTag), .evictData(evictData), .wordIdx(wordIdx), .fillWe(fillWe),
    .storeWe(storeWe), .dStall(dStall), .busReq(dBusReq), .busRsp(dBusRsp)
  );

  // Refill words come straight off the shared read bus
  dataCacheArray dArray (
    .clk(clk), .rstN(rstN), .dataReq(dataReq), .wordIdx(wordIdx), .fillWe(fillWe),
    .storeWe(storeWe), .fillData(dBusRsp.rdata), .hit(hit), .victimDirty(victimDirty),
    .victimTag(victimTag), .rdata(rdata), .evictData(evictData)
  );

  busArbiter arb (
    .clk(clk), .rstN(rstN), .instrReq(iBusReq), .dataReq(dBusReq),
    .instrRsp(iBusRsp), .dataRsp(dBusRsp), .memReq(memReq), .memRsp(memRsp)
  );

  busMemory mem (.clk(clk), .rstN(rstN), .memReq(memReq), .memRsp(memRsp));

endmodule

/* tests/memSystemTb.sv */
`timescale 1ns/1ps
`include "memSysDefs.svh"

module memSystemTb;

  import memSysPkg::*;

  // Word index bits of a byte address inside the memory
  localparam int memAw = $clog2(`MS_MEM_WORDS);
  localparam int stallLimit = 200;

  logic clk;
  logic rstN;
  logic [31:0] pc;
  logic [31:0] instr;
  logic iStall;
  dataReq_t dataReq;
  logic [31:0] rdata;
  logic dStall;

  // Architectural view of memory, what the core should observe
  logic [31:0] refMem [`MS_MEM_WORDS];

  memSystem u_memSystem (
    .clk    (clk),
    .rstN   (rstN),
    .pc     (pc),
    .instr  (instr),
    .iStall (iStall),
    .dataReq(dataReq),
    .rdata  (rdata),
    .dStall (dStall)
  );

  always #20 clk = ~clk;

  initial begin
    for (int a = 0; a < `MS_MEM_WORDS; a++) begin
      refMem[a] = a ^ `MS_INIT_XOR;
    end
  end

  // A store lands on the edge where it is seen without a stall
  always @(posedge clk) begin
    if (rstN && dataReq.write && !dStall) begin
      for (int b = 0; b < 4; b++) begin
        if (dataReq.byteMask[b]) begin
          refMem[dataReq.addr.raw[memAw+1:2]][8*b +: 8] <= dataReq.wdata[8*b +: 8];
        end
      end
    end
  end

  task automatic checkFailed(input string msg);
    $display("Error at time %0t: %s", $time, msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "check failed");
  endtask

  task automatic stallStuck(input string msg);
    $display("%s for %0d cycles, at time %0t", msg, stallLimit, $time);
    $display("TESTBENCH FAILED");
    $fatal(1, "stall timeout");
  endtask

  // Both stalls and every bus request quiet while reset is held
  assert property (@(posedge clk) !rstN |-> !iStall && !dStall && !u_memSystem.memReq.request
                   && !u_memSystem.iBusReq.request && !u_memSystem.dBusReq.request)
    else checkFailed("stall or bus request active during reset");

  // Any unstalled fetch returns the word at pc
  assert property (@(posedge clk) disable iff (!rstN)
    !iStall |-> instr == refMem[pc[memAw+1:2]])
    else checkFailed("fetched instruction differs from memory");

  // Staying inside a block that just hit never stalls again
  assert property (@(posedge clk) disable iff (!rstN)
    $past(rstN) && !$past(iStall) && (pc[31:4] == $past(pc[31:4])) |-> !iStall)
    else checkFailed("repeated fetch from a resident block stalled");

  // Unstalled load returns the merged word at addr
  assert property (@(posedge clk) disable iff (!rstN)
    dataReq.read && !dStall |-> rdata == refMem[dataReq.addr.raw[memAw+1:2]])
    else checkFailed("data load returned a wrong word");

  // Both waits start on the edge where the access was driven
  task automatic iStallWait();
    int cycles;
    cycles = 0;
    @(posedge clk);
    while (iStall) begin
      cycles++;
      if (cycles > stallLimit) stallStuck("Instruction stall stuck high");
      @(posedge clk);
    end
  endtask

  task automatic dStallWait();
    int cycles;
    cycles = 0;
    @(posedge clk);
    while (dStall) begin
      cycles++;
      if (cycles > stallLimit) stallStuck("Data stall stuck high");
      @(posedge clk);
    end
  endtask

  task automatic fetchWord(input logic [31:0] addr);
    pc <= addr;
    iStallWait();
  endtask

  task automatic loadWord(input logic [31:0] addr);
    dataReq.read     <= 1'b1;
    dataReq.write    <= 1'b0;
    dataReq.addr.raw <= addr;
    dStallWait();
  endtask

  task automatic storeWord(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] mask);
    dataReq.read     <= 1'b0;
    dataReq.write    <= 1'b1;
    dataReq.addr.raw <= addr;
    dataReq.wdata    <= data;
    dataReq.byteMask <= mask;
    dStallWait();
    // Store already taken on this edge
    dataReq.write <= 1'b0;
  endtask

  // Both sides miss together and contend for the bus
  task automatic fetchAndLoad(input logic [31:0] iAddr, input logic [31:0] dAddr);
    int cycles;
    cycles = 0;
    pc               <= iAddr;
    dataReq.read     <= 1'b1;
    dataReq.write    <= 1'b0;
    dataReq.addr.raw <= dAddr;
    @(posedge clk);
    while (iStall || dStall) begin
      cycles++;
      if (cycles > stallLimit) begin
        if (iStall) stallStuck("Instruction stall stuck high under contention");
        else stallStuck("Data stall stuck high under contention");
      end
      @(posedge clk);
    end
  endtask

  initial begin
    logic [31:0] base;
    logic [31:0] addr;
    void'($urandom(32'h8804));
    clk     = 1'b0;
    rstN    = 1'b1;
    pc      = '0;
    dataReq = '0;
    @(posedge clk);
    rstN <= 1'b0;
    repeat (2) @(posedge clk);
    rstN <= 1'b1;
    @(posedge clk);

    // Eight fetch blocks, the upper four share lines with the lower four
    for (int k = 0; k < 8; k++) begin
      base = (k % 4) * 32'h10 + (k / 4) * 32'h100;
      // First sweep misses, second must hit
      for (int rep = 0; rep < 2; rep++) begin
        for (int w = 0; w < 4; w++) begin
          fetchWord(base + 4 * w);
        end
      end
    end
    // Block 0 was evicted by block 0x100
    for (int w = 0; w < 4; w++) begin
      fetchWord(4 * w);
    end

    // Random loads and masked stores, two tags over four lines
    for (int n = 0; n < 80; n++) begin
      addr = 32'h800 | (($urandom % 2) << 8) | (($urandom % 4) << 4) | (($urandom % 4) << 2);
      if ($urandom % 2) begin
        storeWord(addr, $urandom, 4'(($urandom % 16)));
      end else begin
        loadWord(addr);
      end
    end
    // Read back the whole region, forcing more dirty evictions
    for (int t = 0; t < 2; t++) begin
      for (int i = 0; i < 16; i++) begin
        loadWord(32'h800 + t * 32'h100 + i * 4);
      end
    end

    // Dirty block 0xc50, evict it with 0xd50, then fetch it
    for (int w = 0; w < 4; w++) begin
      storeWord(32'hc50 + 4 * w, $urandom, 4'(($urandom % 15) + 1));
    end
    loadWord(32'hd50);
    for (int w = 0; w < 4; w++) begin
      fetchWord(32'hc50 + 4 * w);
    end

    // Fetch miss and data miss launched on one edge
    fetchAndLoad(32'h240, 32'he80);
    fetchAndLoad(32'h244, 32'he84);

    repeat (4) @(posedge clk);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+include
logic/memSysPkg.sv
logic/burstTimer.sv
logic/busMemory.sv
logic/busArbiter.sv
logic/instrCache.sv
logic/dataCacheCtrl.sv
logic/dataCacheArray.sv
logic/memSystem.sv
tests/memSystemTb.sv
